// File: project.f
+incdir+source
source/corePkg.sv
source/registerFile.sv
source/instrQueue.sv
source/instrDecoder.sv
source/alu.sv
source/outputPort.sv
source/executionCore.sv
verification/clockGen.sv
verification/core_properties.sv
verification/coreTb.sv

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
        input  logic               clk,
        input  logic               rstN,
        input  corePkg::decodedT   stageInstr,
        output corePkg::writeBackT writeBack,
        output logic               outEmit
);
        import corePkg::*;

        dataWordT result;
        logic     doWrite;
        logic     doOut;

        //////////////////////////////////////////////////
        // Execute
        //////////////////////////////////////////////////

        assign result  = aluResult(stageInstr);
        assign doWrite = stageInstr.valid && writesReg(stageInstr.opcode);
        assign doOut   = stageInstr.valid && (stageInstr.opcode == opOut);

        // Bubbles and NOP leave both enables low
        // OUT carries operandA in the data field with the write enable low
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        writeBack <= '0;
                        outEmit   <= 1'b0;
                end else begin
                        writeBack.we   <= doWrite;
                        writeBack.rd   <= stageInstr.rd;
                        writeBack.data <= result;
                        outEmit        <= doOut;
                end
        end

endmodule

// File: source/corePkg.sv
`include "core_macros.svh"

package corePkg;

        typedef logic [`DATA_WIDTH-1:0]     dataWordT;
        typedef logic [`INSTR_WIDTH-1:0]    instrWordT;
        typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;
        typedef logic [`IMM_WIDTH-1:0]      immT;

        // OUT sends the register named in the rs1 field
        typedef enum logic [`OPCODE_WIDTH-1:0] {
                opNop = `OP_NOP,
                opAdd = `OP_ADD,
                opSub = `OP_SUB,
                opAnd = `OP_AND,
                opOr  = `OP_OR,
                opXor = `OP_XOR,
                opShl = `OP_SHL,
                opShr = `OP_SHR,
                opLdi = `OP_LDI,
                opOut = `OP_OUT
        } opcodeT;

        // Decode stage register
        typedef struct packed {
                opcodeT   opcode;
                regAddrT  rd;
                dataWordT operandA;
                dataWordT operandB;
                logic     valid;
        } decodedT;

        // Execute stage register
        typedef struct packed {
                logic     we;
                regAddrT  rd;
                dataWordT data;
        } writeBackT;

        // True for every operation that updates rd
        function automatic logic writesReg(opcodeT op);
                return (op != opNop) && (op != opOut);
        endfunction

        // Operation result, shared by the ALU and the decode forwarding path
        function automatic dataWordT aluResult(decodedT instr);
                dataWordT result;
                case (instr.opcode)
                        opAdd:   result = instr.operandA + instr.operandB;
                        opSub:   result = instr.operandA - instr.operandB;
                        opAnd:   result = instr.operandA & instr.operandB;
                        opOr:    result = instr.operandA | instr.operandB;
                        opXor:   result = instr.operandA ^ instr.operandB;
                        // Shift amount is the low four bits of rs2
                        opShl:   result = instr.operandA << instr.operandB[3:0];
                        opShr:   result = instr.operandA >> instr.operandB[3:0];
                        opLdi:   result = instr.operandB;
                        opOut:   result = instr.operandA;
                        default: result = '0;
                endcase
                return result;
        endfunction

endpackage

// File: source/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define DATA_WIDTH        16
`define INSTR_WIDTH       16
`define OPCODE_WIDTH      4
`define IMM_WIDTH         8

// Register file
`define REG_COUNT         16
`define REG_ADDR_WIDTH    4

// Input queue depth, equal to the sender's starting credit
`define IN_QUEUE_DEPTH    4

// Output credit counter, holds up to seven credits
`define OUT_CREDIT_WIDTH  3

// Opcodes in bits 15:12 of the instruction word
`define OP_NOP 4'h0
`define OP_ADD 4'h1
`define OP_SUB 4'h2
`define OP_AND 4'h3
`define OP_OR  4'h4
`define OP_XOR 4'h5
`define OP_SHL 4'h6
`define OP_SHR 4'h7
`define OP_LDI 4'h8
`define OP_OUT 4'h9

`endif

// File: source/executionCore.sv
`timescale 1ns/1ps

module executionCore (
        input  logic               clk,
        input  logic               rstN,
        input  logic               inValid,
        input  corePkg::instrWordT inInstr,
        output logic               inCredit,
        input  logic               outCredit,
        output logic               outValid,
        output corePkg::dataWordT  outData
);
        import corePkg::*;

        logic      queueValid;
        instrWordT queueInstr;
        logic      queuePop;
        regAddrT   readAddr1;
        regAddrT   readAddr2;
        dataWordT  readData1;
        dataWordT  readData2;
        decodedT   stageInstr;
        writeBackT writeBack;
        logic      outEmit;
        logic      creditAvail;

        //////////////////////////////////////////////////
        // Input side
        //////////////////////////////////////////////////

        instrQueue uQueue (
                .clk        (clk),
                .rstN       (rstN),
                .inValid    (inValid),
                .inInstr    (inInstr),
                .queuePop   (queuePop),
                .queueValid (queueValid),
                .queueInstr (queueInstr),
                .inCredit   (inCredit)
        );

        // Decode and operand read
        instrDecoder uDecoder (
                .clk         (clk),
                .rstN        (rstN),
                .queueValid  (queueValid),
                .queueInstr  (queueInstr),
                .creditAvail (creditAvail),
                .queuePop    (queuePop),
                .readAddr1   (readAddr1),
                .readAddr2   (readAddr2),
                .readData1   (readData1),
                .readData2   (readData2),
                .stageInstr  (stageInstr)
        );

        registerFile uRegFile (
                .clk       (clk),
                .rstN      (rstN),
                .readAddr1 (readAddr1),
                .readAddr2 (readAddr2),
                .writeBack (writeBack),
                .readData1 (readData1),
                .readData2 (readData2)
        );

        //////////////////////////////////////////////////
        // Execute and output side
        //////////////////////////////////////////////////

        alu uAlu (
                .clk        (clk),
                .rstN       (rstN),
                .stageInstr (stageInstr),
                .writeBack  (writeBack),
                .outEmit    (outEmit)
        );

        outputPort uOutPort (
                .clk         (clk),
                .rstN        (rstN),
                .outCredit   (outCredit),
                .writeBack   (writeBack),
                .outEmit     (outEmit),
                .creditAvail (creditAvail),
                .outValid    (outValid),
                .outData     (outData)
        );

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instrDecoder (
        input  logic               clk,
        input  logic               rstN,
        input  logic               queueValid,
        input  corePkg::instrWordT queueInstr,
        input  logic               creditAvail,
        output logic               queuePop,
        output corePkg::regAddrT   readAddr1,
        output corePkg::regAddrT   readAddr2,
        input  corePkg::dataWordT  readData1,
        input  corePkg::dataWordT  readData2,
        output corePkg::decodedT   stageInstr
);
        import corePkg::*;

        opcodeT   opcode;
        regAddrT  rd;
        regAddrT  rs1;
        regAddrT  rs2;
        immT      imm;
        dataWordT stageResult;
        logic     stageWrites;
        logic     outInAlu;
        logic     outBusy;
        decodedT  decoded;

        //////////////////////////////////////////////////
        // Field split
        //////////////////////////////////////////////////

        // Codes above OUT are unused and run as NOP
        assign opcode = (queueInstr[15:12] > `OP_OUT) ? opNop : opcodeT'(queueInstr[15:12]);
        assign rd     = queueInstr[11:8];
        assign rs1    = queueInstr[7:4];
        assign rs2    = queueInstr[3:0];
        assign imm    = queueInstr[7:0];

        assign readAddr1 = rs1;
        assign readAddr2 = rs2;

        //////////////////////////////////////////////////
        // Operand selection
        //////////////////////////////////////////////////

        // Result of the instruction now in the execute stage
        // Covers a dependence on the immediately preceding word
        assign stageResult = aluResult(stageInstr);
        assign stageWrites = stageInstr.valid && writesReg(stageInstr.opcode);

        always_comb begin
                decoded.opcode = opcode;
                decoded.rd     = rd;
                decoded.valid  = 1'b1;
                if (stageWrites && (stageInstr.rd == rs1)) begin
                        decoded.operandA = stageResult;
                end else begin
                        decoded.operandA = readData1;
                end
                if (opcode == opLdi) begin
                        decoded.operandB = dataWordT'(imm);
                end else if (stageWrites && (stageInstr.rd == rs2)) begin
                        decoded.operandB = stageResult;
                end else begin
                        decoded.operandB = readData2;
                end
        end

        // OUTs still in flight have not yet taken their credit off the counter
        assign outBusy  = (stageInstr.valid && (stageInstr.opcode == opOut)) || outInAlu;
        assign queuePop = queueValid && !((opcode == opOut) && (!creditAvail || outBusy));

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        stageInstr <= '0;
                        outInAlu   <= 1'b0;
                end else begin
                        if (queuePop) begin
                                stageInstr <= decoded;
                        end else begin
                                stageInstr <= '0;
                        end
                        // Tracks the ALU's output beat
                        outInAlu <= stageInstr.valid && (stageInstr.opcode == opOut);
                end
        end

endmodule

// File: source/instrQueue.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module instrQueue (
        input  logic               clk,
        input  logic               rstN,
        input  logic               inValid,
        input  corePkg::instrWordT inInstr,
        input  logic               queuePop,
        output logic               queueValid,
        output corePkg::instrWordT queueInstr,
        output logic               inCredit
);
        import corePkg::*;

        localparam int PTR_WIDTH   = $clog2(`IN_QUEUE_DEPTH);
        localparam int COUNT_WIDTH = $clog2(`IN_QUEUE_DEPTH + 1);

        instrWordT              entries [`IN_QUEUE_DEPTH];
        logic [PTR_WIDTH-1:0]   wrPtr;
        logic [PTR_WIDTH-1:0]   rdPtr;
        logic [COUNT_WIDTH-1:0] fill;
        logic                   popEn;

        // Pointer advance with wrap at the last entry
        function automatic logic [PTR_WIDTH-1:0] nextPtr(logic [PTR_WIDTH-1:0] ptr);
                if (ptr == PTR_WIDTH'(`IN_QUEUE_DEPTH - 1)) begin
                        return '0;
                end
                return ptr + 1'b1;
        endfunction

        assign queueValid = (fill != '0);
        assign queueInstr = entries[rdPtr];
        assign popEn      = queuePop && queueValid;

        // Storage
        // The sender holds a credit for every write so there is always room
        always_ff @(posedge clk) begin
                if (inValid) begin
                        entries[wrPtr] <= inInstr;
                end
        end

        //////////////////////////////////////////////////
        // Pointers, fill level and credit return
        //////////////////////////////////////////////////

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        wrPtr    <= '0;
                        rdPtr    <= '0;
                        fill     <= '0;
                        inCredit <= 1'b0;
                end else begin
                        if (inValid) begin
                                wrPtr <= nextPtr(wrPtr);
                        end
                        if (popEn) begin
                                rdPtr <= nextPtr(rdPtr);
                        end
                        fill     <= fill + COUNT_WIDTH'(inValid) - COUNT_WIDTH'(popEn);
                        // One credit back per freed entry
                        inCredit <= popEn;
                end
        end

endmodule

// File: source/outputPort.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module outputPort (
        input  logic               clk,
        input  logic               rstN,
        input  logic               outCredit,
        input  corePkg::writeBackT writeBack,
        input  logic               outEmit,
        output logic               creditAvail,
        output logic               outValid,
        output corePkg::dataWordT  outData
);

        localparam int CREDIT_WIDTH = `OUT_CREDIT_WIDTH;

        logic [CREDIT_WIDTH-1:0] creditCount;

        assign creditAvail = (creditCount != '0);

        //////////////////////////////////////////////////
        // Credit counter
        //////////////////////////////////////////////////

        // Grant and spend may land on the same edge
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        creditCount <= '0;
                        outValid    <= 1'b0;
                end else begin
                        creditCount <= creditCount + CREDIT_WIDTH'(outCredit)
                                       - CREDIT_WIDTH'(outEmit);
                        outValid    <= outEmit;
                end
        end

        // Output beat data
        always_ff @(posedge clk) begin
                if (outEmit) begin
                        outData <= writeBack.data;
                end
        end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module registerFile (
        input  logic               clk,
        input  logic               rstN,
        input  corePkg::regAddrT   readAddr1,
        input  corePkg::regAddrT   readAddr2,
        input  corePkg::writeBackT writeBack,
        output corePkg::dataWordT  readData1,
        output corePkg::dataWordT  readData2
);
        import corePkg::*;

        dataWordT regs [`REG_COUNT];

        //////////////////////////////////////////////////
        // Write port
        //////////////////////////////////////////////////

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeBack.we) begin
                        regs[writeBack.rd] <= writeBack.data;
                end
        end

        //////////////////////////////////////////////////
        // Read ports
        //////////////////////////////////////////////////

        // Write-through so a reader sees the value landing this cycle
        assign readData1 = (writeBack.we && (writeBack.rd == readAddr1)) ?
                           writeBack.data : regs[readAddr1];

        assign readData2 = (writeBack.we && (writeBack.rd == readAddr2)) ?
                           writeBack.data : regs[readAddr2];

endmodule

// File: verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
        output logic clk,
        output logic rstN
);
        localparam real HALF_PERIOD  = 5.0;
        localparam int  RESET_CYCLES = 16;

        initial begin
                clk = 1'b0;
                forever #HALF_PERIOD clk = ~clk;
        end

        // Release on a falling edge, clear of the sampling edge
        initial begin
                rstN = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rstN = 1'b1;
        end

endmodule

// File: verification/coreTb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module coreTb;
        import corePkg::*;

        // Tests take well under a thousand cycles
        localparam int CYCLE_LIMIT     = 4000;
        localparam int MAX_OUT_CREDITS = 7;

        logic      clk;
        logic      rstN;
        logic      inValid = 1'b0;
        instrWordT inInstr = '0;
        logic      inCredit;
        logic      outCredit = 1'b0;
        logic      outValid;
        dataWordT  outData;

        int        seed = 54462;
        dataWordT  regModel [`REG_COUNT];
        instrWordT sendQ [$];
        dataWordT  expectedQ [$];
        int        inCredits = `IN_QUEUE_DEPTH;
        int        outstanding = 0;
        int        outsIssued = 0;
        int        beatsReceived = 0;
        int        grantRequest = 0;
        int        idleLeft = 0;
        bit        autoCredit = 1'b1;
        bit        randomPace = 1'b0;
        int        errorCount = 0;
        int        checkCount = 0;
        int        testCount = 0;
        int        testStartErrors = 0;
        int        cycleCount = 0;

        clockGen clocks (.clk(clk), .rstN(rstN));

        executionCore DUT (
                .clk       (clk),
                .rstN      (rstN),
                .inValid   (inValid),
                .inInstr   (inInstr),
                .inCredit  (inCredit),
                .outCredit (outCredit),
                .outValid  (outValid),
                .outData   (outData)
        );

        function automatic int unsigned nextRandom();
                return $unsigned($random(seed));
        endfunction

        function automatic int totalErrors();
                return errorCount + DUT.props.failCount;
        endfunction

        function automatic instrWordT makeOp(int op, int rd, int rs1, int rs2);
                return {4'(op), 4'(rd), 4'(rs1), 4'(rs2)};
        endfunction

        function automatic instrWordT makeLdi(int rd, int imm);
                return {`OP_LDI, 4'(rd), 8'(imm)};
        endfunction

        function automatic instrWordT makeOut(int rs);
                return {`OP_OUT, 4'h0, 4'(rs), 4'h0};
        endfunction

        // Reference model of one instruction in program order
        function automatic void issue(instrWordT word);
                dataWordT a;
                dataWordT b;
                a = regModel[word[7:4]];
                b = regModel[word[3:0]];
                case (word[15:12])
                        `OP_ADD: regModel[word[11:8]] = a + b;
                        `OP_SUB: regModel[word[11:8]] = a + ~b + 16'd1;
                        `OP_AND: regModel[word[11:8]] = a & b;
                        `OP_OR:  regModel[word[11:8]] = a | b;
                        `OP_XOR: regModel[word[11:8]] = a ^ b;
                        `OP_SHL: regModel[word[11:8]] = a << b[3:0];
                        `OP_SHR: regModel[word[11:8]] = a >> b[3:0];
                        `OP_LDI: regModel[word[11:8]] = {8'h00, word[7:0]};
                        `OP_OUT: expectedQ.push_back(a);
                        default: ;
                endcase
                sendQ.push_back(word);
        endfunction

        // Scoreboard for one output beat
        function automatic void checkBeat();
                dataWordT expected;
                beatsReceived++;
                outstanding--;
                checkCount++;
                assert (expectedQ.size() != 0) else begin
                        $display("Output beat %h arrived with no OUT pending", outData);
                        errorCount++;
                end
                if (expectedQ.size() != 0) begin
                        expected = expectedQ.pop_front();
                        assert (outData === expected) else begin
                                $display("Error: outData expected %h, got %h", expected, outData);
                                errorCount++;
                        end
                end
        endfunction

        //////////////////////////////////////////////////
        // Sender, sink and output credits
        //////////////////////////////////////////////////

        always @(negedge clk) begin
                outCredit = 1'b0;
                inValid   = 1'b0;
                if (rstN) begin
                        if (inCredit) begin
                                inCredits++;
                        end
                        if (outValid) begin
                                checkBeat();
                        end
                        // Auto mode grants only for OUTs already sent
                        if ((grantRequest > 0) || (autoCredit &&
                            (outstanding < outsIssued - beatsReceived) &&
                            (outstanding < MAX_OUT_CREDITS))) begin
                                outCredit = 1'b1;
                                outstanding++;
                                if (grantRequest > 0) begin
                                        grantRequest--;
                                end
                        end
                        if (idleLeft > 0) begin
                                idleLeft--;
                        end else if ((sendQ.size() != 0) && (inCredits > 0)) begin
                                inInstr = sendQ.pop_front();
                                inValid = 1'b1;
                                inCredits--;
                                if (inInstr[15:12] == `OP_OUT) begin
                                        outsIssued++;
                                end
                                if (randomPace) begin
                                        idleLeft = nextRandom() % 4;
                                end
                        end
                end
        end

        task automatic waitDrain();
                while ((sendQ.size() != 0) || (expectedQ.size() != 0)) begin
                        @(posedge clk);
                end
                repeat (4) @(posedge clk);
        endtask

        task automatic endTest(string name);
                int found;
                found = totalErrors() - testStartErrors;
                testCount++;
                if (found == 0) begin
                        $display("Test %0d %s: passed", testCount, name);
                end else begin
                        $display("Test %0d %s: %0d errors", testCount, name, found);
                end
                testStartErrors = totalErrors();
        endtask

        //////////////////////////////////////////////////
        // Tests
        //////////////////////////////////////////////////

        initial begin
                int base;
                int prev;
                int rd;
                for (int i = 0; i < `REG_COUNT; i++) begin
                        regModel[i] = '0;
                end
                @(posedge rstN);
                @(posedge clk);

                for (int r = 0; r < `REG_COUNT; r++) begin
                        issue(makeOut(r));
                end
                waitDrain();
                endTest("reset state");

                for (int r = 0; r < `REG_COUNT; r++) begin
                        issue(makeLdi(r, nextRandom()));
                        issue(makeOut(r));
                end
                waitDrain();
                endTest("LDI then OUT");

                repeat (24) begin
                        rd = nextRandom() % 16;
                        issue(makeOp(`OP_ADD + nextRandom() % 7, rd,
                                     nextRandom() % 16, nextRandom() % 16));
                        issue(makeOut(rd));
                end
                waitDrain();
                endTest("ALU operations");

                // Each word reads the rd of the one before
                prev = nextRandom() % 16;
                repeat (12) begin
                        rd = nextRandom() % 16;
                        issue(makeOp(`OP_ADD + nextRandom() % 7, rd, prev, nextRandom() % 16));
                        prev = rd;
                end
                for (int r = 0; r < `REG_COUNT; r++) begin
                        issue(makeOut(r));
                end
                waitDrain();
                endTest("back-to-back dependence");

                autoCredit = 1'b0;
                for (int r = 10; r < 14; r++) begin
                        issue(makeLdi(r, nextRandom()));
                end
                issue(makeOut(13));
                issue(makeOut(10));
                issue(makeOut(12));
                issue(makeOut(11));
                base = beatsReceived;
                repeat (30) @(posedge clk);
                checkCount++;
                assert (beatsReceived == base) else begin
                        $display("outValid rose while no output credit was granted");
                        errorCount++;
                end
                for (int i = 1; i <= 4; i++) begin
                        grantRequest = 1;
                        while (beatsReceived < base + i) begin
                                @(posedge clk);
                        end
                        repeat (10) @(posedge clk);
                        checkCount++;
                        assert (beatsReceived == base + i) else begin
                                $display("More than one output beat left for a single credit");
                                errorCount++;
                        end
                end
                autoCredit = 1'b1;
                waitDrain();
                endTest("output back-pressure");

                // Full rate first, then random pauses
                for (int pass = 0; pass < 2; pass++) begin
                        randomPace = (pass == 1);
                        repeat (20) begin
                                case (nextRandom() % 4)
                                        0: issue(makeLdi(nextRandom() % 16, nextRandom()));
                                        1: issue(makeOut(nextRandom() % 16));
                                        default: issue(makeOp(nextRandom() % 8, nextRandom() % 16,
                                                              nextRandom() % 16, nextRandom() % 16));
                                endcase
                        end
                        for (int r = 0; r < `REG_COUNT; r++) begin
                                issue(makeOut(r));
                        end
                        waitDrain();
                end
                randomPace = 1'b0;
                endTest("input credits");

                $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, totalErrors());
                if (totalErrors() == 0) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

        // Watchdog
        initial begin
                while (cycleCount < CYCLE_LIMIT) begin
                        @(posedge clk);
                        cycleCount++;
                end
                $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Something failed");
                $finish;
        end

endmodule

// File: verification/core_properties.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module coreProperties (
        input logic               clk,
        input logic               rstN,
        input logic               inValid,
        input logic               inCredit,
        input logic               queuePop,
        input logic               queueValid,
        input logic               creditAvail,
        input logic               outCredit,
        input logic               outEmit,
        input logic               outValid
);
        import corePkg::*;

        int   failCount = 0;
        int   queueLevel;
        int   creditsGranted;
        int   beatsSeen;
        logic popTaken;

        assign popTaken = queuePop && queueValid;

        // Shadow counts of queue occupancy and output credits
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        queueLevel     <= 0;
                        creditsGranted <= 0;
                        beatsSeen      <= 0;
                end else begin
                        queueLevel     <= queueLevel + int'(inValid) - int'(popTaken);
                        creditsGranted <= creditsGranted + int'(outCredit);
                        beatsSeen      <= beatsSeen + int'(outValid);
                end
        end

        //////////////////////////////////////////////////
        // Reset
        //////////////////////////////////////////////////

        resetQuiet: assert property (@(posedge clk) !rstN |-> (!inCredit && !outValid))
                else begin
                        failCount++;
                        $error("inCredit or outValid high during reset");
                end

        resetRelease: assert property (@(posedge clk) $rose(rstN) |-> (!inCredit && !outValid))
                else begin
                        failCount++;
                        $error("inCredit or outValid high right after reset");
                end

        //////////////////////////////////////////////////
        // Input credits
        //////////////////////////////////////////////////

        noOverflow: assert property (@(posedge clk) disable iff (!rstN)
                        inValid |-> (queueLevel < `IN_QUEUE_DEPTH))
                else begin
                        failCount++;
                        $error("instruction written into a full queue");
                end

        creditAfterPop: assert property (@(posedge clk) disable iff (!rstN)
                        inCredit |-> $past(popTaken))
                else begin
                        failCount++;
                        $error("inCredit without a preceding pop");
                end

        //////////////////////////////////////////////////
        // Output credits and pipeline
        //////////////////////////////////////////////////

        outWithinCredit: assert property (@(posedge clk) disable iff (!rstN)
                        outValid |-> (beatsSeen < creditsGranted))
                else begin
                        failCount++;
                        $error("outValid beyond the credits granted");
                end

        // The counter must still hold the credit an emitted OUT spends
        emitWithCredit: assert property (@(posedge clk) disable iff (!rstN)
                        outEmit |-> creditAvail)
                else begin
                        failCount++;
                        $error("OUT emitted with the credit counter at zero");
                end

endmodule

bind executionCore coreProperties props (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inCredit    (inCredit),
        .queuePop    (queuePop),
        .queueValid  (queueValid),
        .creditAvail (creditAvail),
        .outCredit   (outCredit),
        .outEmit     (outEmit),
        .outValid    (outValid)
);
